/* rv_exec.f */
+incdir+verif
design/rv_pkg.sv
design/rv_decoder.sv
design/rv_alu.sv
design/rv_regfile.sv
design/rv_apb_ctrl.sv
design/rv_exec_top.sv
verif/rv_exec_tb.sv

/* verif/rv_tb_checks.svh */
`ifndef RV_TB_CHECKS_SVH
`define RV_TB_CHECKS_SVH

// Cycles to wait for pready before giving up
localparam int WAIT_LIMIT = 16;

// 64-bit register, result and PC values
task automatic check_data(input string name, input logic [63:0] got, input logic [63:0] exp);
    checks++;
    if (got !== exp) begin
        errors++;
        $display("** Error %s: got 0x%h, expected 0x%h", name, got, exp);
    end
endtask

// STATUS word, legal in bit 0, pipe in bits 3:1, wb_en in bit 4
task automatic check_status(input string name, input logic [31:0] got, input rv_optype_e ot,
                            input logic legal, input logic wb_en);
    logic [31:0] exp;
    exp = {27'b0, wb_en, ot, legal};
    checks++;
    if (got !== exp) begin
        errors++;
        $display("** Error %s: got 0x%h, expected 0x%h", name, got, exp);
    end
endtask

// Single-bit response flags such as pslverr
task automatic check_flag(input string name, input logic got, input logic exp);
    checks++;
    if (got !== exp) begin
        errors++;
        $display("** Error %s: got 0x%h, expected 0x%h", name, got, exp);
    end
endtask

// One APB transfer, setup then access, sampled at the completing edge
task automatic apb_xfer(input logic write, input logic [11:0] addr, input logic [31:0] wdata,
                        output logic [31:0] rdata, output logic err);
    int waited;
    waited = 0;
    @(negedge clk);
    apb_req.psel    = 1'b1;
    apb_req.penable = 1'b0;
    apb_req.pwrite  = write;
    apb_req.paddr   = addr;
    apb_req.pwdata  = wdata;
    @(negedge clk);
    apb_req.penable = 1'b1;
    @(posedge clk);
    while (!apb_rsp.pready && (waited < WAIT_LIMIT)) begin
        waited++;
        @(posedge clk);
    end
    if (apb_rsp.pready) begin
        rdata = apb_rsp.prdata;
        err   = apb_rsp.pslverr;
        // Back to idle before the next edge
        @(negedge clk);
        apb_req.psel    = 1'b0;
        apb_req.penable = 1'b0;
        apb_req.pwrite  = 1'b0;
    end else begin
        $display("APB transfer to address 0x%h never completed, pready stayed low", addr);
        timeouts++;
        finish_run();
    end
endtask

task automatic apb_write(input logic [11:0] addr, input logic [31:0] data, output logic err);
    logic [31:0] unused;
    apb_xfer(1'b1, addr, data, unused, err);
endtask

task automatic apb_read(input logic [11:0] addr, output logic [31:0] data, output logic err);
    apb_xfer(1'b0, addr, 32'h0, data, err);
endtask

`endif

/* verif/rv_exec_tb.sv */
`timescale 1ns/100ps

module rv_exec_tb import rv_pkg::*;;

    logic        clk;
    logic        rst_n;
    rv_apb_req_t apb_req;
    rv_apb_rsp_t apb_rsp;

    int checks;
    int errors;
    int timeouts;

    // Expected register file, PC and result
    logic [63:0] rf [32];
    logic [63:0] pc_m;
    logic [63:0] res_m;

    rv_exec_top DUT (
        .clk     (clk),
        .rst_n   (rst_n),
        .apb_req (apb_req),
        .apb_rsp (apb_rsp)
    );

    `include "rv_tb_checks.svh"

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    task automatic finish_run();
        $display("Checks run: %0d, errors: %0d, timeouts: %0d", checks, errors, timeouts);
        if ((errors == 0) && (timeouts == 0)) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    endtask

    // Instruction encoders
    function automatic logic [31:0] enc_r(input logic [6:0] f7, input logic [4:0] rs2,
                                          input logic [4:0] rs1, input logic [2:0] f3,
                                          input logic [4:0] rd, input logic [6:0] opc);
        return {f7, rs2, rs1, f3, rd, opc};
    endfunction

    function automatic logic [31:0] enc_i(input logic [11:0] imm, input logic [4:0] rs1,
                                          input logic [2:0] f3, input logic [4:0] rd,
                                          input logic [6:0] opc);
        return {imm, rs1, f3, rd, opc};
    endfunction

    function automatic logic [31:0] enc_s(input logic [11:0] imm, input logic [4:0] rs2,
                                          input logic [4:0] rs1, input logic [2:0] f3);
        return {imm[11:5], rs2, rs1, f3, imm[4:0], OP_STORE};
    endfunction

    function automatic logic [31:0] enc_u(input logic [19:0] imm, input logic [4:0] rd,
                                          input logic [6:0] opc);
        return {imm, rd, opc};
    endfunction

    function automatic logic [63:0] sext32(input logic [31:0] x);
        return {{32{x[31]}}, x};
    endfunction

    function automatic logic [63:0] sext12(input logic [11:0] x);
        return {{52{x[11]}}, x};
    endfunction

    // RV64I integer functions where W forms work on the low word and sign-extend
    function automatic logic [63:0] alu_ref(input logic [2:0] f3, input logic alt,
                                            input logic word, input logic [63:0] a,
                                            input logic [63:0] b);
        logic [63:0]        r;
        logic [31:0]        r32;
        logic signed [31:0] s32;
        logic signed [63:0] s64;
        int                 sh;
        if (word) begin
            sh = b[4:0];
            case (f3)
                3'd0: r32 = alt ? (a[31:0] - b[31:0]) : (a[31:0] + b[31:0]);
                3'd1: r32 = a[31:0] << sh;
                3'd4: r32 = a[31:0] ^ b[31:0];
                3'd5: begin
                    s32 = a[31:0];
                    s32 = s32 >>> sh;
                    r32 = alt ? s32 : (a[31:0] >> sh);
                end
                3'd6: r32 = a[31:0] | b[31:0];
                3'd7: r32 = a[31:0] & b[31:0];
                default: r32 = '0;
            endcase
            r = sext32(r32);
        end else begin
            sh = b[5:0];
            case (f3)
                3'd0: r = alt ? (a - b) : (a + b);
                3'd1: r = a << sh;
                3'd2: r = ($signed(a) < $signed(b)) ? 64'd1 : 64'd0;
                3'd3: r = (a < b) ? 64'd1 : 64'd0;
                3'd4: r = a ^ b;
                3'd5: begin
                    s64 = a;
                    s64 = s64 >>> sh;
                    r = alt ? s64 : (a >> sh);
                end
                3'd6: r = a | b;
                default: r = a & b;
            endcase
        end
        return r;
    endfunction

    function automatic logic [11:0] reg_addr(input logic [4:0] idx);
        return ADDR_REG_BASE + {4'b0, idx, 3'b000};
    endfunction

    // 64-bit value as low word then high word
    task automatic write64(input logic [11:0] lo_addr, input logic [63:0] data);
        logic err;
        apb_write(lo_addr, data[31:0], err);
        check_flag($sformatf("pslverr at 0x%h", lo_addr), err, 1'b0);
        apb_write(lo_addr + 12'd4, data[63:32], err);
        check_flag($sformatf("pslverr at 0x%h", lo_addr + 12'd4), err, 1'b0);
    endtask

    task automatic read64(input logic [11:0] lo_addr, output logic [63:0] data);
        logic err;
        apb_read(lo_addr, data[31:0], err);
        check_flag($sformatf("pslverr at 0x%h", lo_addr), err, 1'b0);
        apb_read(lo_addr + 12'd4, data[63:32], err);
        check_flag($sformatf("pslverr at 0x%h", lo_addr + 12'd4), err, 1'b0);
    endtask

    task automatic set_reg(input logic [4:0] idx, input logic [63:0] val);
        write64(reg_addr(idx), val);
        if (idx != 5'd0) begin
            rf[idx] = val;
        end
    endtask

    task automatic check_all_regs();
        logic [63:0] got;
        for (int i = 0; i < 32; i++) begin
            read64(reg_addr(5'(i)), got);
            check_data($sformatf("x%0d", i), got, rf[i]);
        end
    endtask

    // Issue one legal word and check result, STATUS, rd and PC
    task automatic exec_check(input string name, input logic [31:0] word,
                              input logic [63:0] exp, input rv_optype_e ot, input logic wb);
        logic        err;
        logic [63:0] got;
        logic [31:0] st;
        logic [4:0]  rd;
        rd = word[11:7];
        apb_write(ADDR_INSTR, word, err);
        check_flag({name, " pslverr"}, err, 1'b0);
        pc_m  = pc_m + 64'd4;
        res_m = exp;
        // Only integer ops write back since loads have no memory behind them
        if ((ot == OT_INT) && wb && (rd != 5'd0)) begin
            rf[rd] = exp;
        end
        read64(ADDR_RES_LO, got);
        check_data({name, " result"}, got, exp);
        apb_read(ADDR_STATUS, st, err);
        check_status({name, " status"}, st, ot, 1'b1, wb);
        read64(reg_addr(rd), got);
        check_data({name, " rd"}, got, rf[rd]);
        read64(ADDR_PC_LO, got);
        check_data({name, " pc"}, got, pc_m);
    endtask

    task automatic reset_and_reg_access();
        logic [63:0] got;
        logic [31:0] st;
        logic        err;
        read64(ADDR_PC_LO, got);
        check_data("pc after reset", got, 64'd0);
        read64(ADDR_RES_LO, got);
        check_data("result after reset", got, 64'd0);
        apb_read(ADDR_STATUS, st, err);
        check_status("status after reset", st, OT_INT, 1'b0, 1'b0);
        for (int i = 1; i < 32; i++) begin
            set_reg(5'(i), {$urandom, $urandom});
        end
        // x0 ignores the write
        set_reg(5'd0, {$urandom, $urandom});
        check_all_regs();
    endtask

    task automatic reg_reg_ops();
        logic [2:0]  f3;
        logic        alt;
        logic [4:0]  rs1;
        logic [4:0]  rs2;
        logic [4:0]  rd;
        logic [63:0] a;
        logic [63:0] b;
        // Eight funct3 codes followed by SUB and SRA
        for (int k = 0; k < 10; k++) begin
            f3  = (k < 8) ? 3'(k) : ((k == 8) ? 3'd0 : 3'd5);
            alt = (k >= 8);
            rs1 = 5'($urandom_range(31, 1));
            rs2 = (rs1 % 5'd31) + 5'd1;
            rd  = 5'($urandom_range(31, 1));
            a   = {$urandom, $urandom};
            b   = {$urandom, $urandom};
            set_reg(rs1, a);
            set_reg(rs2, b);
            exec_check($sformatf("OP f3=%0d alt=%0d", f3, alt),
                       enc_r({1'b0, alt, 5'b0}, rs2, rs1, f3, rd, OP_INTREG),
                       alu_ref(f3, alt, 1'b0, a, b), OT_INT, 1'b1);
        end
    endtask

    task automatic imm_and_w_ops();
        logic [4:0]  rs1;
        logic [4:0]  rs2;
        logic [4:0]  rd;
        logic [63:0] a;
        logic [63:0] b;
        logic [11:0] imm;
        logic [5:0]  sh;
        rs1 = 5'($urandom_range(31, 1));
        rs2 = (rs1 % 5'd31) + 5'd1;
        rd  = 5'($urandom_range(31, 1));
        a   = {$urandom, $urandom};
        b   = {$urandom, $urandom};
        imm = 12'($urandom);
        sh  = 6'($urandom);
        set_reg(rs1, a);
        set_reg(rs2, b);
        exec_check("ADDI", enc_i(imm, rs1, 3'd0, rd, OP_INTIMM), a + sext12(imm),
                   OT_INT, 1'b1);
        a = rf[rs1];
        exec_check("SLLI", enc_i({6'b0, sh}, rs1, 3'd1, rd, OP_INTIMM),
                   alu_ref(3'd1, 1'b0, 1'b0, a, 64'(sh)), OT_INT, 1'b1);
        a = rf[rs1];
        exec_check("SRLI", enc_i({6'b0, sh}, rs1, 3'd5, rd, OP_INTIMM),
                   alu_ref(3'd5, 1'b0, 1'b0, a, 64'(sh)), OT_INT, 1'b1);
        // Arithmetic shift selected by funct7 bit 5
        a = rf[rs1];
        exec_check("SRAI", enc_i({6'b010000, sh}, rs1, 3'd5, rd, OP_INTIMM),
                   alu_ref(3'd5, 1'b1, 1'b0, a, 64'(sh)), OT_INT, 1'b1);
        a = rf[rs1];
        exec_check("ADDIW", enc_i(imm, rs1, 3'd0, rd, OP_INTIMMW),
                   alu_ref(3'd0, 1'b0, 1'b1, a, sext12(imm)), OT_INT, 1'b1);
        a = rf[rs1];
        exec_check("SLLIW", enc_i({7'b0, sh[4:0]}, rs1, 3'd1, rd, OP_INTIMMW),
                   alu_ref(3'd1, 1'b0, 1'b1, a, 64'(sh[4:0])), OT_INT, 1'b1);
        a = rf[rs1];
        exec_check("SRAIW", enc_i({7'b0100000, sh[4:0]}, rs1, 3'd5, rd, OP_INTIMMW),
                   alu_ref(3'd5, 1'b1, 1'b1, a, 64'(sh[4:0])), OT_INT, 1'b1);
        a = rf[rs1];
        b = rf[rs2];
        exec_check("SUBW", enc_r(7'h20, rs2, rs1, 3'd0, rd, OP_INTREGW),
                   alu_ref(3'd0, 1'b1, 1'b1, a, b), OT_INT, 1'b1);
    endtask

    task automatic upper_imm_ops();
        logic [63:0] got;
        logic [19:0] imm;
        logic [4:0]  rd;
        pc_m = {$urandom, $urandom} & ~64'h3;
        write64(ADDR_PC_LO, pc_m);
        read64(ADDR_PC_LO, got);
        check_data("pc after host write", got, pc_m);
        imm = 20'($urandom);
        rd  = 5'($urandom_range(31, 1));
        exec_check("AUIPC", enc_u(imm, rd, OP_AUIPC), pc_m + sext32({imm, 12'b0}),
                   OT_INT, 1'b1);
        // Top bit set so the sign extension shows
        imm = 20'($urandom) | 20'h80000;
        rd  = 5'($urandom_range(31, 1));
        exec_check("LUI", enc_u(imm, rd, OP_LUI), sext32({imm, 12'b0}), OT_INT, 1'b1);
    endtask

    task automatic load_store_addr();
        logic [4:0]  rs1;
        logic [4:0]  rs2;
        logic [4:0]  rd;
        logic [11:0] imm;
        logic [63:0] a;
        rs1 = 5'($urandom_range(31, 1));
        rs2 = (rs1 % 5'd31) + 5'd1;
        rd  = 5'($urandom_range(31, 1));
        a   = rf[rs1];
        imm = 12'($urandom);
        exec_check("LD", enc_i(imm, rs1, 3'b011, rd, OP_LOAD), a + sext12(imm),
                   OT_LOAD, 1'b1);
        imm = 12'($urandom) | 12'h800;
        exec_check("LBU", enc_i(imm, rs1, 3'b100, rd, OP_LOAD), a + sext12(imm),
                   OT_LOAD, 1'b1);
        imm = 12'($urandom);
        exec_check("SD", enc_s(imm, rs2, rs1, 3'b011), a + sext12(imm), OT_STORE, 1'b0);
        check_all_regs();
    endtask

    task automatic error_responses();
        logic        err;
        logic [31:0] st;
        logic [31:0] data;
        logic [63:0] got;
        // BEQ opcode is outside the decoded set
        apb_write(ADDR_INSTR, enc_r(7'h0, 5'd2, 5'd1, 3'd0, 5'd0, 7'b1100011), err);
        check_flag("branch pslverr", err, 1'b1);
        apb_read(ADDR_STATUS, st, err);
        check_status("branch status", st, OT_INT, 1'b0, 1'b0);
        read64(ADDR_PC_LO, got);
        check_data("pc after branch", got, pc_m);
        read64(ADDR_RES_LO, got);
        check_data("result after branch", got, res_m);
        check_all_regs();
        apb_read(12'h020, data, err);
        check_flag("unmapped read pslverr", err, 1'b1);
        apb_write(ADDR_RES_LO, $urandom, err);
        check_flag("RES_LO write pslverr", err, 1'b1);
        read64(ADDR_RES_LO, got);
        check_data("result after RES_LO write", got, res_m);
    endtask

    initial begin
        void'($urandom(32'h5787e3a7));
        checks   = 0;
        errors   = 0;
        timeouts = 0;
        apb_req  = '0;
        rst_n    = 1'b0;
        pc_m     = '0;
        res_m    = '0;
        for (int i = 0; i < 32; i++) begin
            rf[i] = '0;
        end
        repeat (10) @(negedge clk);
        rst_n = 1'b1;
        reset_and_reg_access();
        reg_reg_ops();
        imm_and_w_ops();
        upper_imm_ops();
        load_store_addr();
        error_responses();
        finish_run();
    end

endmodule

/* design/rv_exec_top.sv */
`timescale 1ns/100ps

module rv_exec_top import rv_pkg::*; (
    input  logic        clk,
    input  logic        rst_n,
    input  rv_apb_req_t apb_req,
    output rv_apb_rsp_t apb_rsp
);

    rv_instr_u   instr;
    rv_decode_t  dec;
    logic [63:0] alu_a;
    logic [63:0] alu_b;
    logic [63:0] alu_result;
    logic [63:0] rs1_data;
    logic [63:0] rs2_data;
    logic        wr_en;
    logic [4:0]  wr_idx;
    logic [63:0] wr_data;
    logic [4:0]  host_idx;
    logic        host_hi;
    logic        host_we;
    logic [31:0] host_wdata;
    logic [31:0] host_rdata;

    // APB slave, PC and writeback control
    rv_apb_ctrl u_ctrl (
        .clk        (clk),
        .rst_n      (rst_n),
        .apb_req    (apb_req),
        .apb_rsp    (apb_rsp),
        .instr      (instr),
        .dec        (dec),
        .alu_a      (alu_a),
        .alu_b      (alu_b),
        .alu_result (alu_result),
        .rs1_data   (rs1_data),
        .rs2_data   (rs2_data),
        .wr_en      (wr_en),
        .wr_idx     (wr_idx),
        .wr_data    (wr_data),
        .host_idx   (host_idx),
        .host_hi    (host_hi),
        .host_we    (host_we),
        .host_wdata (host_wdata),
        .host_rdata (host_rdata)
    );

    rv_decoder u_dec (
        .instr (instr),
        .dec   (dec)
    );

    rv_alu u_alu (
        .op       (dec.op),
        .option   (dec.option),
        .truncate (dec.truncate),
        .a        (alu_a),
        .b        (alu_b),
        .result   (alu_result)
    );

    // Operand reads indexed straight from the decoded fields
    rv_regfile u_rf (
        .clk        (clk),
        .rst_n      (rst_n),
        .rs1_idx    (dec.rs1),
        .rs2_idx    (dec.rs2),
        .rs1_data   (rs1_data),
        .rs2_data   (rs2_data),
        .wr_en      (wr_en),
        .wr_idx     (wr_idx),
        .wr_data    (wr_data),
        .host_idx   (host_idx),
        .host_hi    (host_hi),
        .host_we    (host_we),
        .host_wdata (host_wdata),
        .host_rdata (host_rdata)
    );

endmodule

/* design/rv_apb_ctrl.sv */
`timescale 1ns/100ps

module rv_apb_ctrl import rv_pkg::*; (
    input  logic        clk,
    input  logic        rst_n,
    input  rv_apb_req_t apb_req,
    output rv_apb_rsp_t apb_rsp,
    output rv_instr_u   instr,
    input  rv_decode_t  dec,
    output logic [63:0] alu_a,
    output logic [63:0] alu_b,
    input  logic [63:0] alu_result,
    input  logic [63:0] rs1_data,
    input  logic [63:0] rs2_data,
    output logic        wr_en,
    output logic [4:0]  wr_idx,
    output logic [63:0] wr_data,
    output logic [4:0]  host_idx,
    output logic        host_hi,
    output logic        host_we,
    output logic [31:0] host_wdata,
    input  logic [31:0] host_rdata
);

    logic [63:0] pc;
    logic [63:0] result;
    // {wb_en, op_type, legal}
    logic [4:0]  status;
    logic [11:0] addr;
    logic        access;
    logic        wr_acc;
    logic        in_win;
    logic        read_only;
    logic        mapped;
    logic        instr_wr;
    logic        exec;

    assign addr   = apb_req.paddr;
    assign access = apb_req.psel & apb_req.penable;
    assign wr_acc = access & apb_req.pwrite;

    // Word-aligned register window 0x100 to 0x1FC
    assign in_win    = (addr[11:8] == ADDR_REG_BASE[11:8]) && (addr[1:0] == 2'b00);
    assign read_only = addr inside {ADDR_RES_LO, ADDR_RES_HI, ADDR_STATUS};
    assign mapped    = in_win || read_only || (addr inside {ADDR_INSTR, ADDR_PC_LO, ADDR_PC_HI});
    assign instr_wr  = wr_acc && (addr == ADDR_INSTR);
    // Only a legal word commits
    assign exec      = instr_wr && dec.legal;

    // Decode straight off the write data
    assign instr = apb_req.pwdata;

    always_comb begin
        case (dec.operand1)
            OPR1_PC:  alu_a = pc;
            OPR1_RS1: alu_a = rs1_data;
            default:  alu_a = '0;
        endcase
    end

    // Loads and stores add the immediate for the effective address
    assign alu_b = ((dec.op_type != OT_INT) || (dec.operand2 == OPR2_IMM)) ? dec.imm : rs2_data;

    // No data memory, so loads leave the register file alone
    assign wr_en   = exec && dec.wb_en && (dec.op_type == OT_INT) && (dec.rd != 5'd0);
    assign wr_idx  = dec.rd;
    assign wr_data = alu_result;

    // Register window index in bits 7:3 and half select in bit 2
    assign host_idx   = addr[7:3];
    assign host_hi    = addr[2];
    assign host_we    = wr_acc && in_win;
    assign host_wdata = apb_req.pwdata;

    always_comb begin
        if (in_win) begin
            apb_rsp.prdata = host_rdata;
        end else begin
            case (addr)
                ADDR_PC_LO:  apb_rsp.prdata = pc[31:0];
                ADDR_PC_HI:  apb_rsp.prdata = pc[63:32];
                ADDR_RES_LO: apb_rsp.prdata = result[31:0];
                ADDR_RES_HI: apb_rsp.prdata = result[63:32];
                ADDR_STATUS: apb_rsp.prdata = {27'b0, status};
                default:     apb_rsp.prdata = '0;
            endcase
        end
    end

    // Zero wait states
    assign apb_rsp.pready  = 1'b1;
    assign apb_rsp.pslverr = access && (!mapped || (apb_req.pwrite && read_only) ||
                                        (instr_wr && !dec.legal));

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pc     <= '0;
            result <= '0;
            status <= '0;
        end else begin
            if (exec) begin
                result <= alu_result;
                pc     <= pc + 64'd4;
            end else if (wr_acc && (addr == ADDR_PC_LO)) begin
                pc[31:0] <= apb_req.pwdata;
            end else if (wr_acc && (addr == ADDR_PC_HI)) begin
                pc[63:32] <= apb_req.pwdata;
            end
            // Illegal words still report here
            if (instr_wr) begin
                status <= {dec.wb_en, dec.op_type, dec.legal};
            end
        end
    end

    a_penable_psel: assert property (@(posedge clk) disable iff (!rst_n)
        apb_req.penable |-> apb_req.psel);

endmodule

/* design/rv_regfile.sv */
`timescale 1ns/100ps

module rv_regfile (
    input  logic        clk,
    input  logic        rst_n,
    input  logic [4:0]  rs1_idx,
    input  logic [4:0]  rs2_idx,
    output logic [63:0] rs1_data,
    output logic [63:0] rs2_data,
    input  logic        wr_en,
    input  logic [4:0]  wr_idx,
    input  logic [63:0] wr_data,
    input  logic [4:0]  host_idx,
    input  logic        host_hi,
    input  logic        host_we,
    input  logic [31:0] host_wdata,
    output logic [31:0] host_rdata
);

    // x0 has no storage
    logic [63:0] regs [1:31];
    logic [63:0] host_word;

    assign rs1_data  = (rs1_idx == 5'd0) ? 64'd0 : regs[rs1_idx];
    assign rs2_data  = (rs2_idx == 5'd0) ? 64'd0 : regs[rs2_idx];
    assign host_word = (host_idx == 5'd0) ? 64'd0 : regs[host_idx];

    // Host sees one 32-bit half per access
    assign host_rdata = host_hi ? host_word[63:32] : host_word[31:0];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 1; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_en && (wr_idx != 5'd0)) begin
            regs[wr_idx] <= wr_data;
        end else if (host_we && (host_idx != 5'd0)) begin
            // Other half keeps its value
            if (host_hi) begin
                regs[host_idx][63:32] <= host_wdata;
            end else begin
                regs[host_idx][31:0] <= host_wdata;
            end
        end
    end

    // Writeback and host window come from different APB addresses
    a_one_writer: assert property (@(posedge clk) disable iff (!rst_n)
        !(wr_en && host_we));

endmodule

/* design/rv_alu.sv */
`timescale 1ns/100ps

module rv_alu import rv_pkg::*; (
    input  rv_alu_op_e  op,
    input  logic        option,
    input  logic        truncate,
    input  logic [63:0] a,
    input  logic [63:0] b,
    output logic [63:0] result
);

    logic [5:0]         shamt;
    logic [63:0]        sum;
    logic [63:0]        a_shr;
    logic [63:0]        srl_res;
    logic signed [63:0] sra_res;
    logic [63:0]        raw;

    // W forms shift by at most 31
    assign shamt = truncate ? {1'b0, b[4:0]} : b[5:0];

    assign sum = option ? (a - b) : (a + b);

    // Right shift source, W forms see only the low word
    always_comb begin
        if (!truncate) begin
            a_shr = a;
        end else if (option) begin
            a_shr = {{32{a[31]}}, a[31:0]};
        end else begin
            a_shr = {32'b0, a[31:0]};
        end
    end

    assign srl_res = a_shr >> shamt;
    assign sra_res = $signed(a_shr) >>> shamt;

    always_comb begin
        case (op)
            ALU_ADDSUB: raw = sum;
            ALU_SLL:    raw = a << shamt;
            ALU_SLT:    raw = {63'b0, $signed(a) < $signed(b)};
            ALU_SLTU:   raw = {63'b0, a < b};
            ALU_XOR:    raw = a ^ b;
            ALU_SRLSRA: raw = option ? sra_res : srl_res;
            ALU_OR:     raw = a | b;
            ALU_AND:    raw = a & b;
            default:    raw = sum;
        endcase
    end

    // W results are sign-extended from bit 31
    assign result = truncate ? {{32{raw[31]}}, raw[31:0]} : raw;

endmodule

/* design/rv_decoder.sv */
`timescale 1ns/100ps

module rv_decoder import rv_pkg::*; (
    input  rv_instr_u  instr,
    output rv_decode_t dec
);

    logic [2:0]  funct3;
    logic        shift_right;
    logic [63:0] imm_i;
    logic [63:0] imm_s;
    logic [63:0] imm_u;

    assign funct3      = instr.r.funct3;
    assign shift_right = (funct3 == ALU_SRLSRA);

    // Sign-extended immediates for the formats in use
    assign imm_i = {{52{instr.r.funct7[6]}}, instr.r.funct7, instr.r.rs2};
    assign imm_s = {{52{instr.s.imm_hi[6]}}, instr.s.imm_hi, instr.s.imm_lo};
    assign imm_u = {{32{instr.s.imm_hi[6]}}, instr.s.imm_hi, instr.s.rs2,
                    instr.s.rs1, instr.s.funct3, 12'b0};

    always_comb begin
        // Illegal until an opcode matches
        dec.op        = ALU_ADDSUB;
        dec.option    = 1'b0;
        dec.truncate  = 1'b0;
        dec.mem_sign  = 1'b0;
        dec.mem_width = 2'b00;
        dec.op_type   = OT_INT;
        dec.operand1  = OPR1_ZERO;
        dec.operand2  = OPR2_RS2;
        dec.imm       = '0;
        dec.legal     = 1'b0;
        dec.wb_en     = 1'b0;
        // Register fields pass through for every format
        dec.rs1       = instr.r.rs1;
        dec.rs2       = instr.r.rs2;
        dec.rd        = instr.r.rd;

        case (instr.r.opcode)
            OP_LUI: begin
                // 0 + imm
                dec.imm      = imm_u;
                dec.operand2 = OPR2_IMM;
                dec.wb_en    = 1'b1;
                dec.legal    = 1'b1;
            end
            OP_AUIPC: begin
                // PC + imm
                dec.imm      = imm_u;
                dec.operand1 = OPR1_PC;
                dec.operand2 = OPR2_IMM;
                dec.wb_en    = 1'b1;
                dec.legal    = 1'b1;
            end
            OP_INTIMM, OP_INTIMMW: begin
                dec.op       = rv_alu_op_e'(funct3);
                // No SUBI, so funct7 only selects SRAI over SRLI
                dec.option   = shift_right & instr.r.funct7[5];
                dec.truncate = (instr.r.opcode == OP_INTIMMW);
                dec.imm      = imm_i;
                dec.operand1 = OPR1_RS1;
                dec.operand2 = OPR2_IMM;
                dec.wb_en    = 1'b1;
                dec.legal    = 1'b1;
            end
            OP_INTREG, OP_INTREGW: begin
                dec.op       = rv_alu_op_e'(funct3);
                // SUB and SRA
                dec.option   = instr.r.funct7[5];
                dec.truncate = (instr.r.opcode == OP_INTREGW);
                dec.operand1 = OPR1_RS1;
                dec.operand2 = OPR2_RS2;
                dec.wb_en    = 1'b1;
                dec.legal    = 1'b1;
            end
            OP_LOAD: begin
                dec.op_type   = OT_LOAD;
                dec.mem_sign  = funct3[2];
                dec.mem_width = funct3[1:0];
                dec.imm       = imm_i;
                dec.operand1  = OPR1_RS1;
                dec.operand2  = OPR2_IMM;
                dec.wb_en     = 1'b1;
                dec.legal     = 1'b1;
            end
            OP_STORE: begin
                // rs2 is store data while the address still comes from rs1 + imm
                dec.op_type   = OT_STORE;
                dec.mem_sign  = funct3[2];
                dec.mem_width = funct3[1:0];
                dec.imm       = imm_s;
                dec.operand1  = OPR1_RS1;
                dec.operand2  = OPR2_RS2;
                dec.legal     = 1'b1;
            end
            default: begin
                // Branches, jumps, system and extensions stay illegal
                dec.legal = 1'b0;
            end
        endcase
    end

endmodule

/* design/rv_pkg.sv */
package rv_pkg;

    // Major opcodes handled by the execution slice
    typedef enum logic [6:0] {
        OP_LUI     = 7'b0110111,
        OP_AUIPC   = 7'b0010111,
        OP_INTIMM  = 7'b0010011,
        OP_INTREG  = 7'b0110011,
        OP_INTIMMW = 7'b0011011,
        OP_INTREGW = 7'b0111011,
        OP_LOAD    = 7'b0000011,
        OP_STORE   = 7'b0100011
    } rv_opcode_e;

    // Pipe that would execute the instruction
    typedef enum logic [2:0] {
        OT_INT   = 3'd0,
        OT_LOAD  = 3'd1,
        OT_STORE = 3'd2
    } rv_optype_e;

    // ALU function, same encoding as funct3
    typedef enum logic [2:0] {
        ALU_ADDSUB = 3'b000,
        ALU_SLL    = 3'b001,
        ALU_SLT    = 3'b010,
        ALU_SLTU   = 3'b011,
        ALU_XOR    = 3'b100,
        ALU_SRLSRA = 3'b101,
        ALU_OR     = 3'b110,
        ALU_AND    = 3'b111
    } rv_alu_op_e;

    typedef enum logic [1:0] {
        OPR1_ZERO = 2'd0,
        OPR1_PC   = 2'd1,
        OPR1_RS1  = 2'd2
    } rv_opr1_e;

    typedef enum logic [1:0] {
        OPR2_RS2 = 2'd0,
        OPR2_IMM = 2'd1
    } rv_opr2_e;

    // R and I formats share this field split
    typedef struct packed {
        logic [6:0] funct7;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        logic [6:0] opcode;
    } rv_instr_r_t;

    // S format, upper 20 bits double as the U immediate
    typedef struct packed {
        logic [6:0] imm_hi;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] imm_lo;
        logic [6:0] opcode;
    } rv_instr_s_t;

    typedef union packed {
        rv_instr_r_t r;
        rv_instr_s_t s;
    } rv_instr_u;

    typedef struct packed {
        rv_alu_op_e  op;
        // Subtract or arithmetic shift
        logic        option;
        // 32-bit W operation
        logic        truncate;
        logic        mem_sign;
        logic [1:0]  mem_width;
        rv_optype_e  op_type;
        rv_opr1_e    operand1;
        rv_opr2_e    operand2;
        logic [63:0] imm;
        logic        legal;
        logic        wb_en;
        logic [4:0]  rs1;
        logic [4:0]  rs2;
        logic [4:0]  rd;
    } rv_decode_t;

    typedef struct packed {
        logic        psel;
        logic        penable;
        logic        pwrite;
        logic [11:0] paddr;
        logic [31:0] pwdata;
    } rv_apb_req_t;

    typedef struct packed {
        logic [31:0] prdata;
        logic        pready;
        logic        pslverr;
    } rv_apb_rsp_t;

    // APB register map
    localparam logic [11:0] ADDR_INSTR    = 12'h000;
    localparam logic [11:0] ADDR_PC_LO    = 12'h004;
    localparam logic [11:0] ADDR_PC_HI    = 12'h008;
    localparam logic [11:0] ADDR_RES_LO   = 12'h00C;
    localparam logic [11:0] ADDR_RES_HI   = 12'h010;
    localparam logic [11:0] ADDR_STATUS   = 12'h014;
    // Register n low word at base + 8n, high word at base + 8n + 4
    localparam logic [11:0] ADDR_REG_BASE = 12'h100;

endpackage
